// ==== sim.f ====
+incdir+verification
source/rv_retire_pkg.sv
source/step_cmp_pkg.sv
source/clknrst_if.sv
source/retire_capture.sv
source/step_sequencer.sv
source/retire_comparator.sv
source/step_compare_top.sv
verification/step_compare_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module step_compare_tb -f sim.f \
    -o step_compare_sim > sim.log 2>&1 \
    && ./obj_dir/step_compare_sim >> sim.log 2>&1 \
    || echo "Build or run ended with an error" >> sim.log
cat sim.log
grep -q "Simulation FAILED" sim.log && exit 1
grep -q "Simulation PASSED" sim.log || exit 1
exit 0

// ==== verification/step_compare_model.svh ====
// Lockstep checker model that predicts the mismatch flags of one compare from two records
`ifndef STEP_COMPARE_MODEL_SVH
`define STEP_COMPARE_MODEL_SVH

// Expected flags for one processor record and one reference record
function automatic step_cmp_pkg::mismatch_t predict_mismatch(
    input rv_retire_pkg::retire_rec_t dut_side,
    input rv_retire_pkg::retire_rec_t ref_side,
    input logic                       stall
);
    step_cmp_pkg::mismatch_t m;
    logic                    gpr_live;

    // Address and data count only when both write and not both target x0
    gpr_live = dut_side.gpr_we && ref_side.gpr_we
        && ((dut_side.gpr_addr | ref_side.gpr_addr) != '0);
    m.pc_bad  = (dut_side.pc != ref_side.pc);
    m.gpr_bad = (dut_side.gpr_we != ref_side.gpr_we)
        || (gpr_live && ({dut_side.gpr_addr, dut_side.gpr_data}
                         != {ref_side.gpr_addr, ref_side.gpr_data}));
    // Whole CSR set, masked in stall mode
    m.csr_bad = !stall && (dut_side.csrs != ref_side.csrs);
    return m;
endfunction

// Any flag raised, feeds the running sticky prediction
function automatic logic any_flag(input step_cmp_pkg::mismatch_t m);
    return m.pc_bad || m.gpr_bad || m.csr_bad;
endfunction

`endif

// ==== verification/step_compare_tb.sv ====
// Lockstep checker testbench with random processor and reference streams checked against a model
`timescale 1ns/1ns
`default_nettype none

module step_compare_tb;

    // Planned instructions, also sizes the watchdog
    localparam int num_insns = 400;

    clknrst_if clk_rst ();

    // DUT inputs
    logic                       dut_strobe;
    rv_retire_pkg::retire_rec_t dut_rec;
    logic                       ref_strobe;
    rv_retire_pkg::retire_rec_t ref_rec;
    logic                       stall_mode;

    // DUT outputs
    logic                             dut_go;
    logic                             ref_step;
    logic                             cmp_done;
    step_cmp_pkg::mismatch_t          mismatch;
    logic                             miscompare;
    logic [step_cmp_pkg::count_w-1:0] insn_count;

    // Number of cmp_done_o cycles seen so far
    int unsigned done_seen = 0;

    `include "step_compare_model.svh"

    step_compare_top step_compare_top_i (
        .clknrst_if   (clk_rst),
        .dut_strobe_i (dut_strobe),
        .dut_rec_i    (dut_rec),
        .ref_strobe_i (ref_strobe),
        .ref_rec_i    (ref_rec),
        .stall_mode_i (stall_mode),
        .dut_go_o     (dut_go),
        .ref_step_o   (ref_step),
        .cmp_done_o   (cmp_done),
        .mismatch_o   (mismatch),
        .miscompare_o (miscompare),
        .insn_count_o (insn_count)
    );

    // 10 ns clock
    initial begin
        clk_rst.clk_i = 1'b0;
        forever #5 clk_rst.clk_i = ~clk_rst.clk_i;
    end

    // Stray done pulses show up as a count ahead of the instruction index
    always @(negedge clk_rst.clk_i) begin
        if (cmp_done) begin
            done_seen <= done_seen + 1;
        end
    end

    // Compares stuck for too long
    initial begin
        repeat (num_insns * 200 + 10) @(posedge clk_rst.clk_i);
        $display("Watchdog expired because compares stopped arriving");
        $display("Simulation FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            $display("Simulation FAILED");
            $fatal(1, "stopping on first error");
        end
    endtask

    // Random record of a given kind, x0 targets made common
    function automatic rv_retire_pkg::retire_rec_t random_record(
        input rv_retire_pkg::ret_kind_e kind
    );
        rv_retire_pkg::retire_rec_t rec;
        logic [31:0]                rnd;

        rnd               = $urandom;
        rec.kind          = kind;
        rec.pc            = $urandom;
        rec.gpr_we        = 1'($urandom);
        rec.gpr_addr      = (($urandom % 4) == 0) ? '0 : rnd[rv_retire_pkg::gpr_addr_w-1:0];
        rec.gpr_data      = $urandom;
        rec.csrs.mstatus  = $urandom;
        rec.csrs.mepc     = $urandom;
        rec.csrs.mcause   = $urandom;
        rec.csrs.mtvec    = $urandom;
        return rec;
    endfunction

    // Copy with one random field flipped by a single bit
    function automatic rv_retire_pkg::retire_rec_t corrupt_record(
        input rv_retire_pkg::retire_rec_t rec
    );
        rv_retire_pkg::retire_rec_t bad;
        logic [31:0]                flip;
        logic [31:0]                addr_flip;

        bad       = rec;
        flip      = 32'h1 << ($urandom % 32);
        addr_flip = 32'h1 << ($urandom % rv_retire_pkg::gpr_addr_w);
        case ($urandom % 8)
            0: bad.pc = bad.pc ^ flip;
            1: bad.gpr_we = ~bad.gpr_we;
            2: bad.gpr_addr = bad.gpr_addr ^ addr_flip[rv_retire_pkg::gpr_addr_w-1:0];
            3: bad.gpr_data = bad.gpr_data ^ flip;
            4: bad.csrs.mstatus = bad.csrs.mstatus ^ flip;
            5: bad.csrs.mepc = bad.csrs.mepc ^ flip;
            6: bad.csrs.mcause = bad.csrs.mcause ^ flip;
            default: bad.csrs.mtvec = bad.csrs.mtvec ^ flip;
        endcase
        return bad;
    endfunction

    // One rising edge of stimulus on either stream
    task automatic drive_cycle(input logic to_ref, input logic strobe,
                               input rv_retire_pkg::retire_rec_t rec);
        @(posedge clk_rst.clk_i);
        if (to_ref) begin
            ref_strobe <= strobe;
            ref_rec    <= rec;
        end else begin
            dut_strobe <= strobe;
            dut_rec    <= rec;
        end
    endtask

    // Idle cycles, maybe trap or halt records, then the real retirement
    // Returns right after the edge that samples the valid strobe
    task automatic send_retirement(input logic to_ref, input rv_retire_pkg::retire_rec_t rec);
        int unsigned n_wait;
        int unsigned n_junk;

        n_wait = $urandom % 4;
        n_junk = (($urandom % 4) == 0) ? 32'd1 + ($urandom % 2) : 32'd0;
        repeat (n_wait) drive_cycle(to_ref, 1'b0, rec);
        repeat (n_junk) begin
            drive_cycle(to_ref, 1'b1, random_record((($urandom % 2) == 0)
                ? rv_retire_pkg::ret_trap : rv_retire_pkg::ret_halt));
        end
        drive_cycle(to_ref, 1'b1, rec);
        drive_cycle(to_ref, 1'b0, rec);
    endtask

    initial begin
        rv_retire_pkg::retire_rec_t dut_val;
        rv_retire_pkg::retire_rec_t ref_val;
        step_cmp_pkg::mismatch_t    exp_flags;
        logic                       exp_sticky;
        logic                       stall_val;

        void'($urandom(32'he178));
        clk_rst.rst_n_i = 1'b0;
        dut_strobe      = 1'b0;
        dut_rec         = '0;
        ref_strobe      = 1'b0;
        ref_rec         = '0;
        stall_mode      = 1'b0;
        exp_sticky      = 1'b0;

        // Outputs held quiet inside the 4 reset cycles
        repeat (3) @(posedge clk_rst.clk_i);
        @(negedge clk_rst.clk_i);
        check_value("dut_go_o", 32'(dut_go), 32'h0);
        check_value("ref_step_o", 32'(ref_step), 32'h0);
        check_value("cmp_done_o", 32'(cmp_done), 32'h0);
        check_value("miscompare_o", 32'(miscompare), 32'h0);
        check_value("insn_count_o", insn_count, 32'h0);
        @(posedge clk_rst.clk_i);
        clk_rst.rst_n_i <= 1'b1;

        for (int i = 0; i < num_insns; i++) begin
            // Processor turn, stall mode picked per instruction
            @(negedge clk_rst.clk_i);
            while (!dut_go) begin
                @(negedge clk_rst.clk_i);
            end
            stall_val = 1'($urandom);
            @(posedge clk_rst.clk_i);
            stall_mode <= stall_val;
            dut_val = random_record(rv_retire_pkg::ret_valid);
            send_retirement(1'b0, dut_val);

            // Reference turn after the step request
            @(negedge clk_rst.clk_i);
            while (!ref_step) begin
                @(negedge clk_rst.clk_i);
            end
            check_value("dut_go_o", 32'(dut_go), 32'h0);
            ref_val = (($urandom % 2) == 0) ? dut_val : corrupt_record(dut_val);
            send_retirement(1'b1, ref_val);

            // Done exactly two edges after the reference strobe is sampled
            @(negedge clk_rst.clk_i);
            check_value("cmp_done_o", 32'(cmp_done), 32'h0);
            @(negedge clk_rst.clk_i);
            check_value("cmp_done_o", 32'(cmp_done), 32'h0);
            @(negedge clk_rst.clk_i);
            check_value("cmp_done_o", 32'(cmp_done), 32'h1);

            exp_flags  = predict_mismatch(dut_val, ref_val, stall_val);
            exp_sticky = exp_sticky || any_flag(exp_flags);
            check_value("mismatch_o", 32'(mismatch), 32'(exp_flags));
            check_value("miscompare_o", 32'(miscompare), 32'(exp_sticky));
            check_value("insn_count_o", insn_count, 32'(i + 1));
            check_value("cmp_done_o pulses", done_seen, 32'(i));
        end

        @(negedge clk_rst.clk_i);
        check_value("cmp_done_o pulses", done_seen, 32'(num_insns));
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/step_compare_top.sv ====
// Lockstep checker top with two stream captures, the step sequencer and the comparator
`timescale 1ns/1ns
`default_nettype none

module step_compare_top (
    clknrst_if.sink                          clknrst_if,
    input  wire logic                        dut_strobe_i,
    input  wire rv_retire_pkg::retire_rec_t  dut_rec_i,
    input  wire logic                        ref_strobe_i,
    input  wire rv_retire_pkg::retire_rec_t  ref_rec_i,
    input  wire logic                        stall_mode_i,
    output logic                             dut_go_o,
    output logic                             ref_step_o,
    output logic                             cmp_done_o,
    output step_cmp_pkg::mismatch_t          mismatch_o,
    output logic                             miscompare_o,
    output logic [step_cmp_pkg::count_w-1:0] insn_count_o
);

    // Held records and their full levels
    rv_retire_pkg::retire_rec_t dut_rec;
    rv_retire_pkg::retire_rec_t ref_rec;
    logic                       dut_full;
    logic                       ref_full;

    // Compare cycle, also consumes both held records
    logic cmp_en;

    // Processor stream
    retire_capture dut_capture (
        .clknrst_if (clknrst_if),
        .strobe_i   (dut_strobe_i),
        .rec_i      (dut_rec_i),
        .consume_i  (cmp_en),
        .rec_o      (dut_rec),
        .full_o     (dut_full)
    );

    // Reference stream
    retire_capture ref_capture (
        .clknrst_if (clknrst_if),
        .strobe_i   (ref_strobe_i),
        .rec_i      (ref_rec_i),
        .consume_i  (cmp_en),
        .rec_o      (ref_rec),
        .full_o     (ref_full)
    );

    step_sequencer step_sequencer_i (
        .clknrst_if (clknrst_if),
        .dut_full_i (dut_full),
        .ref_full_i (ref_full),
        .dut_go_o   (dut_go_o),
        .ref_step_o (ref_step_o),
        .cmp_en_o   (cmp_en)
    );

    retire_comparator retire_comparator_i (
        .clknrst_if   (clknrst_if),
        .cmp_en_i     (cmp_en),
        .dut_rec_i    (dut_rec),
        .ref_rec_i    (ref_rec),
        .stall_mode_i (stall_mode_i),
        .cmp_done_o   (cmp_done_o),
        .mismatch_o   (mismatch_o),
        .miscompare_o (miscompare_o),
        .insn_count_o (insn_count_o)
    );

endmodule

`default_nettype wire

// ==== source/retire_comparator.sv ====
// Retirement comparator that judges two held records and keeps the sticky flag and the count
`timescale 1ns/1ns
`default_nettype none

module retire_comparator (
    clknrst_if.sink                         clknrst_if,
    input  wire logic                       cmp_en_i,
    input  wire rv_retire_pkg::retire_rec_t dut_rec_i,
    input  wire rv_retire_pkg::retire_rec_t ref_rec_i,
    input  wire logic                       stall_mode_i,
    output logic                            cmp_done_o,
    output step_cmp_pkg::mismatch_t         mismatch_o,
    output logic                            miscompare_o,
    output logic [step_cmp_pkg::count_w-1:0] insn_count_o
);

    // Flags for the records currently held
    step_cmp_pkg::mismatch_t flags;

    always_comb begin
        logic both_write;
        logic both_x0;
        logic csr_diff;

        // Program counter
        flags.pc_bad = (dut_rec_i.pc != ref_rec_i.pc);

        // Write enables must agree
        // Address and data only matter when both write somewhere other than x0
        both_write    = dut_rec_i.gpr_we && ref_rec_i.gpr_we;
        both_x0       = (dut_rec_i.gpr_addr == '0) && (ref_rec_i.gpr_addr == '0);
        flags.gpr_bad = (dut_rec_i.gpr_we != ref_rec_i.gpr_we);
        if (both_write && !both_x0) begin
            flags.gpr_bad = flags.gpr_bad
                || (dut_rec_i.gpr_addr != ref_rec_i.gpr_addr)
                || (dut_rec_i.gpr_data != ref_rec_i.gpr_data);
        end

        // CSR words as one xlen slice each
        csr_diff = 1'b0;
        for (int i = 0; i < rv_retire_pkg::csr_count; i++) begin
            if (dut_rec_i.csrs[i*rv_retire_pkg::xlen +: rv_retire_pkg::xlen]
                != ref_rec_i.csrs[i*rv_retire_pkg::xlen +: rv_retire_pkg::xlen]) begin
                csr_diff = 1'b1;
            end
        end
        // CSR timing is not exact under bus stalls
        flags.csr_bad = csr_diff && !stall_mode_i;
    end

    // Done strobe, sticky flag and counter
    always_ff @(posedge clknrst_if.clk_i) begin
        if (!clknrst_if.rst_n_i) begin
            cmp_done_o   <= 1'b0;
            miscompare_o <= 1'b0;
            insn_count_o <= '0;
        end else begin
            cmp_done_o <= cmp_en_i;
            if (cmp_en_i) begin
                miscompare_o <= miscompare_o || (|flags);
                insn_count_o <= insn_count_o + step_cmp_pkg::count_w'(1);
            end
        end
    end

    // Result flags are valid while cmp_done_o is high
    always_ff @(posedge clknrst_if.clk_i) begin
        if (cmp_en_i) begin
            mismatch_o <= flags;
        end
    end

endmodule

`default_nettype wire

// ==== source/step_sequencer.sv ====
// Step sequencer that lets the processor retire, then the reference, then triggers the compare
`timescale 1ns/1ns
`default_nettype none

module step_sequencer (
    clknrst_if.sink   clknrst_if,
    input  wire logic dut_full_i,
    input  wire logic ref_full_i,
    output logic      dut_go_o,
    output logic      ref_step_o,
    output logic      cmp_en_o
);

    // Current and next state
    step_cmp_pkg::seq_state_e state_q;
    step_cmp_pkg::seq_state_e state_d;

    // State register
    always_ff @(posedge clknrst_if.clk_i) begin
        if (!clknrst_if.rst_n_i) begin
            state_q <= step_cmp_pkg::seq_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        unique case (state_q)
            step_cmp_pkg::seq_idle: begin
                state_d = step_cmp_pkg::seq_dut_step;
            end
            step_cmp_pkg::seq_dut_step: begin
                // Processor has retired one instruction
                if (dut_full_i) begin
                    state_d = step_cmp_pkg::seq_ref_step;
                end
            end
            step_cmp_pkg::seq_ref_step: begin
                // Reference may take any number of cycles
                if (ref_full_i) begin
                    state_d = step_cmp_pkg::seq_cmp;
                end
            end
            step_cmp_pkg::seq_cmp: begin
                // Single compare cycle, then the next processor step
                state_d = step_cmp_pkg::seq_dut_step;
            end
            default: begin
                state_d = step_cmp_pkg::seq_idle;
            end
        endcase
    end

    // Processor may retire while its capture is still empty
    // Drops in the same cycle the capture reports full
    assign dut_go_o = (state_q == step_cmp_pkg::seq_dut_step) && !dut_full_i;

    // Reference step request, high for the last cycle of seq_dut_step
    assign ref_step_o = (state_q == step_cmp_pkg::seq_dut_step) && dut_full_i;

    // Compare enable, also used as consume by both captures
    assign cmp_en_o = (state_q == step_cmp_pkg::seq_cmp);

    // One step request per processor retirement
    a_ref_step_pulse : assert property (
        @(posedge clknrst_if.clk_i) disable iff (!clknrst_if.rst_n_i)
        ref_step_o |=> !ref_step_o
    ) else $error("step_sequencer: ref_step_o held for more than one cycle");

    // Never compare with an empty capture on either stream
    a_cmp_both_full : assert property (
        @(posedge clknrst_if.clk_i) disable iff (!clknrst_if.rst_n_i)
        cmp_en_o |-> (dut_full_i && ref_full_i)
    ) else $error("step_sequencer: compare started without two held records");

endmodule

`default_nettype wire

// ==== source/retire_capture.sv ====
// Retirement capture that holds one valid record from one stream until it is consumed
`timescale 1ns/1ns
`default_nettype none

module retire_capture (
    clknrst_if.sink                   clknrst_if,
    input  wire logic                 strobe_i,
    input  wire rv_retire_pkg::retire_rec_t rec_i,
    input  wire logic                 consume_i,
    output rv_retire_pkg::retire_rec_t rec_o,
    output logic                      full_o
);

    // Strobe that carries a real retirement
    // Trap and halt records fall out here
    logic valid_strobe;

    assign valid_strobe = strobe_i && (rec_i.kind == rv_retire_pkg::ret_valid);

    // Full flag
    // Set on the edge after a valid strobe, cleared by the compare
    always_ff @(posedge clknrst_if.clk_i) begin
        if (!clknrst_if.rst_n_i) begin
            full_o <= 1'b0;
        end else if (valid_strobe) begin
            full_o <= 1'b1;
        end else if (consume_i) begin
            full_o <= 1'b0;
        end
    end

    // Held record
    // Loaded only by valid strobes, so a trap or halt leaves it untouched
    always_ff @(posedge clknrst_if.clk_i) begin
        if (valid_strobe) begin
            rec_o <= rec_i;
        end
    end

    // The stream must wait until the sequencer has consumed the held record
    // A valid strobe into a full capture would overwrite an uncompared record
    a_no_strobe_when_full : assert property (
        @(posedge clknrst_if.clk_i) disable iff (!clknrst_if.rst_n_i)
        valid_strobe |-> !full_o
    ) else $error("retire_capture: valid strobe while holding an uncompared record");

endmodule

`default_nettype wire

// ==== source/clknrst_if.sv ====
// Clock and reset bundle carrying the clock and the synchronous active-low reset
`timescale 1ns/1ns
`default_nettype none

interface clknrst_if;

    // Free-running clock
    logic clk_i;

    // Synchronous reset, active low
    logic rst_n_i;

    // View for blocks that only consume clock and reset
    modport sink (
        input clk_i,
        input rst_n_i
    );

endinterface

`default_nettype wire

// ==== source/step_cmp_pkg.sv ====
// Checker package with the counter width, the sequencer states and the mismatch flags
`default_nettype none

package step_cmp_pkg;

    // Width of the compared instruction counter
    localparam int unsigned count_w = 32;

    // Sequencer states
    // seq_idle is left on the first edge after reset
    // seq_dut_step waits for the processor to retire one instruction
    // seq_ref_step waits for the reference to retire one instruction
    // seq_cmp lasts one cycle and triggers the compare
    typedef enum logic [1:0] {
        seq_idle,
        seq_dut_step,
        seq_ref_step,
        seq_cmp
    } seq_state_e;

    // Per-compare result flags
    // Each bit is judged independently of the others
    typedef struct packed {
        // Program counters differ
        logic pc_bad;
        // Register write-back differs, x0 writes excluded
        logic gpr_bad;
        // CSR values differ, masked in stall mode
        logic csr_bad;
    } mismatch_t;

endpackage

`default_nettype wire

// ==== source/rv_retire_pkg.sv ====
// Retirement record package with the record kind, the CSR set and the full retired record
`default_nettype none

package rv_retire_pkg;

    // Data and address width of the core
    localparam int unsigned xlen = 32;

    // Register file address width
    localparam int unsigned gpr_addr_w = 5;

    // Number of CSR words carried in each record
    localparam int unsigned csr_count = 4;

    // Kind of retirement event on a stream
    // Only ret_valid records take part in a compare
    typedef enum logic [1:0] {
        ret_valid,
        ret_trap,
        ret_halt
    } ret_kind_e;

    // Compared CSR values, mstatus in the top word
    typedef struct packed {
        logic [xlen-1:0] mstatus;
        logic [xlen-1:0] mepc;
        logic [xlen-1:0] mcause;
        logic [xlen-1:0] mtvec;
    } csr_set_t;

    // One retired instruction as seen on a stream
    typedef struct packed {
        ret_kind_e             kind;
        logic [xlen-1:0]       pc;
        logic                  gpr_we;
        logic [gpr_addr_w-1:0] gpr_addr;
        logic [xlen-1:0]       gpr_data;
        csr_set_t              csrs;
    } retire_rec_t;

endpackage

`default_nettype wire
